// ==== flist.f ====
+incdir+source
source/wb_load_pkg.sv
source/wb_if.sv
source/wb_dummy_requester.sv
source/wb_bus_arbiter.sv
source/wb_shared_bus.sv
source/wb_ram_slave.sv
source/wb_load_top.sv
tests/wb_load_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f flist.f --top-module wb_load_tb &&
./obj_dir/Vwb_load_tb ||
{ echo "simulation did not pass"; exit 1; }

// ==== tests/wb_load_tb.sv ====
// ==============================
// Wishbone load testbench
// ==============================

`include "wb_load_params.svh"

module wb_load_tb
    import wb_load_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW    = `WB_AW;
    localparam int DW    = `WB_DW;
    localparam int SELW  = `WB_SELW;
    localparam int DEPTH = 1 << AW;

    // Busy cycles of one requester ownership are the grant, the ack and the hold
    localparam int HOLD_BUSY     = `REQ_LEN_CLK_NUM_DEF + 3;
    // Two requester holds with their idle gaps, plus our own grant and ack
    localparam int SERVICE_BOUND = 2 * (HOLD_BUSY + 1) + 6;
    localparam int MAX_GAP       = 3;
    localparam int NUM_MERGE     = 40;
    localparam int NUM_RANDOM    = 400;
    localparam int NUM_TXN       = DEPTH + 2 + 2 * NUM_MERGE + NUM_RANDOM + 2;
    localparam longint WATCHDOG_CYCLES = NUM_TXN * (SERVICE_BOUND + MAX_GAP + 2) + 200;

    localparam logic [AW-1:0] REQ1_ADDR = 8'h10;
    localparam logic [AW-1:0] REQ2_ADDR = 8'h20;

    logic              clk;
    logic              reset;
    logic              ext_cyc_i;
    logic              ext_stb_i;
    logic              ext_we_i;
    logic [AW-1:0]     ext_addr_i;
    logic [SELW-1:0]   ext_sel_i;
    logic [DW-1:0]     ext_dat_i;
    logic [DW-1:0]     ext_dat_o;
    logic              ext_ack_o;
    master_idx_t       bus_owner_o;
    logic              bus_busy_o;

    // Expected RAM contents
    logic [DW-1:0]     model [DEPTH];
    bit [3:0]          owner_seen;
    logic              ack_prev;
    logic              ext_owned_prev;

    wb_load_top wb_load_top_inst (
        .clk         (clk),
        .reset       (reset),
        .ext_cyc_i   (ext_cyc_i),
        .ext_stb_i   (ext_stb_i),
        .ext_we_i    (ext_we_i),
        .ext_addr_i  (ext_addr_i),
        .ext_sel_i   (ext_sel_i),
        .ext_dat_i   (ext_dat_i),
        .ext_dat_o   (ext_dat_o),
        .ext_ack_o   (ext_ack_o),
        .bus_owner_o (bus_owner_o),
        .bus_busy_o  (bus_busy_o)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("error at %0d ns: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    // Selected bytes come from the new word and the others stay
    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0]   old_word,
                                                  input logic [DW-1:0]   new_word,
                                                  input logic [SELW-1:0] sel);
        logic [DW-1:0] res;
        res = old_word;
        for (int b = 0; b < SELW; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
        return {a, ~a, a ^ 8'h5a, {a[3:0], a[7:4]}};
    endfunction

    // Starts and returns 1 ns after a rising edge
    // A gap of 0 keeps cyc high for the next access
    task automatic bus_access(input logic we, input logic [AW-1:0] addr,
                              input logic [SELW-1:0] sel, input logic [DW-1:0] wdat,
                              input int gap, output logic [DW-1:0] rdat);
        int wait_cycles;
        wait_cycles = 0;
        ext_cyc_i  = 1'b1;
        ext_stb_i  = 1'b1;
        ext_we_i   = we;
        ext_addr_i = addr;
        ext_sel_i  = sel;
        ext_dat_i  = wdat;
        @(negedge clk);
        while (!ext_ack_o) begin
            wait_cycles++;
            if (wait_cycles > SERVICE_BOUND) begin
                report_failure($sformatf("request to address %h got no ack within %0d cycles",
                                         addr, SERVICE_BOUND));
            end
            @(negedge clk);
        end
        rdat = ext_dat_o;
        @(posedge clk);
        #1;
        if (gap > 0) begin
            ext_cyc_i = 1'b0;
            ext_stb_i = 1'b0;
            ext_we_i  = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // Ack shape and bus ownership monitor
    always @(negedge clk) begin
        if (!reset) begin
            if (ext_ack_o) begin
                check_value("ext_stb_i at ext_ack_o", 32'(ext_stb_i), 32'd1);
                check_value("ext_ack_o one cycle earlier", 32'(ack_prev), 32'd0);
            end
            if (bus_busy_o) begin
                owner_seen[bus_owner_o] = 1'b1;
            end
            if (ext_owned_prev && ext_cyc_i) begin
                check_value("bus_busy_o", 32'(bus_busy_o), 32'd1);
                check_value("bus_owner_o", 32'(bus_owner_o), 32'd0);
            end
            ack_prev       = ext_ack_o;
            ext_owned_prev = bus_busy_o && (bus_owner_o == 2'd0) && ext_cyc_i;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        logic [31:0]     r;
        logic [AW-1:0]   addr;
        logic [SELW-1:0] sel;
        logic [DW-1:0]   data;
        logic [DW-1:0]   rdat;
        int              gap;
        int              wait_cycles;

        clk            = 1'b0;
        reset          = 1'b1;
        ext_cyc_i      = 1'b0;
        ext_stb_i      = 1'b0;
        ext_we_i       = 1'b0;
        ext_addr_i     = '0;
        ext_sel_i      = '0;
        ext_dat_i      = '0;
        owner_seen     = '0;
        ack_prev       = 1'b0;
        ext_owned_prev = 1'b0;
        void'($urandom(83));

        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Quiet bus while both requesters count their idle gap
        repeat (`REQ_WAIT_CLK_NUM_DEF) begin
            @(negedge clk);
            check_value("bus_busy_o", 32'(bus_busy_o), 32'd0);
            check_value("ext_ack_o", 32'(ext_ack_o), 32'd0);
        end
        wait_cycles = 0;
        while (!bus_busy_o) begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 4) begin
                report_failure("bus_busy_o did not rise after the requester idle gap");
            end
        end
        @(posedge clk);
        #1;

        // Known contents everywhere
        for (int a = 0; a < DEPTH; a++) begin
            addr = AW'(a);
            gap  = $urandom_range(MAX_GAP, 0);
            bus_access(1'b1, addr, '1, fill_word(addr), gap, rdat);
            model[addr] = fill_word(addr);
        end

        // Full word write then read back
        r    = $urandom;
        addr = r[AW-1:0];
        data = $urandom;
        bus_access(1'b1, addr, '1, data, 1, rdat);
        model[addr] = data;
        bus_access(1'b0, addr, '1, '0, 1, rdat);
        check_value("ext_dat_o", rdat, data);

        // Partial writes each read back against the merged word
        for (int i = 0; i < NUM_MERGE; i++) begin
            r    = $urandom;
            addr = r[AW-1:0];
            sel  = r[8 +: SELW];
            data = $urandom;
            gap  = $urandom_range(MAX_GAP, 0);
            bus_access(1'b1, addr, sel, data, gap, rdat);
            model[addr] = merge_bytes(model[addr], data, sel);
            bus_access(1'b0, addr, '1, '0, gap, rdat);
            check_value("ext_dat_o", rdat, model[addr]);
        end

        // Mixed traffic that hits the requester addresses often
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $urandom;
            if (r[2:0] == 3'd0) begin
                addr = r[3] ? REQ1_ADDR : REQ2_ADDR;
            end else begin
                addr = r[24 +: AW];
            end
            sel  = r[8 +: SELW];
            data = $urandom;
            gap  = $urandom_range(MAX_GAP, 0);
            bus_access(r[4], addr, sel, data, gap, rdat);
            if (r[4]) begin
                model[addr] = merge_bytes(model[addr], data, sel);
            end else begin
                check_value("ext_dat_o", rdat, model[addr]);
            end
        end

        bus_access(1'b0, REQ1_ADDR, '1, '0, 1, rdat);
        check_value("ext_dat_o", rdat, model[REQ1_ADDR]);
        bus_access(1'b0, REQ2_ADDR, '1, '0, 1, rdat);
        check_value("ext_dat_o", rdat, model[REQ2_ADDR]);

        ext_cyc_i = 1'b0;
        ext_stb_i = 1'b0;
        ext_we_i  = 1'b0;
        repeat (4) @(posedge clk);

        check_value("bus_owner_o indices seen", 32'(owner_seen), 32'h7);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== source/wb_load_top.sv ====
// ==============================
// Wishbone load subsystem
// ==============================

`include "wb_load_params.svh"

module wb_load_top
    import wb_load_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                ext_cyc_i,
    input  logic                ext_stb_i,
    input  logic                ext_we_i,
    input  logic [`WB_AW-1:0]   ext_addr_i,
    input  logic [`WB_SELW-1:0] ext_sel_i,
    input  logic [`WB_DW-1:0]   ext_dat_i,
    output logic [`WB_DW-1:0]   ext_dat_o,
    output logic                ext_ack_o,
    output master_idx_t         bus_owner_o,
    output logic                bus_busy_o
);

    wb_if ext_bus ();
    wb_if req1_bus ();
    wb_if req2_bus ();
    wb_if ram_bus ();

    // External port becomes master 0
    assign ext_bus.cyc  = ext_cyc_i;
    assign ext_bus.stb  = ext_stb_i;
    assign ext_bus.we   = ext_we_i;
    assign ext_bus.addr = ext_addr_i;
    assign ext_bus.sel  = ext_sel_i;
    assign ext_bus.cti  = CTI_CLASSIC;
    assign ext_bus.wdat = ext_dat_i;
    assign ext_dat_o    = ext_bus.rdat;
    assign ext_ack_o    = ext_bus.ack;

    wb_dummy_requester #(
        .BASE_ADDR (8'h10)
    ) wb_dummy_requester_1_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (req1_bus)
    );

    wb_dummy_requester #(
        .BASE_ADDR (8'h20)
    ) wb_dummy_requester_2_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (req2_bus)
    );

    wb_shared_bus wb_shared_bus_inst (
        .clk     (clk),
        .reset   (reset),
        .m0      (ext_bus),
        .m1      (req1_bus),
        .m2      (req2_bus),
        .s       (ram_bus),
        .owner_o (bus_owner_o),
        .busy_o  (bus_busy_o)
    );

    wb_ram_slave wb_ram_slave_inst (
        .clk   (clk),
        .reset (reset),
        .bus   (ram_bus)
    );

endmodule

// ==== source/wb_ram_slave.sv ====
// ==============================
// Wishbone RAM slave
// ==============================

`include "wb_load_params.svh"

module wb_ram_slave (
    input  logic clk,
    input  logic reset,
    wb_if.slave  bus
);

    localparam int DEPTH = 1 << `WB_AW;

    logic [`WB_DW-1:0] mem [DEPTH];
    logic [`WB_DW-1:0] rdat_q;
    logic              ack_q;
    logic              access;

    // A new access starts on every stb cycle that is not already being acked,
    // so each strobe gets exactly one ack pulse
    assign access = bus.cyc && bus.stb && !ack_q;

    // Byte-select write merge and registered read
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus.we) begin
                for (int b = 0; b < `WB_SELW; b++) begin
                    if (bus.sel[b]) begin
                        mem[bus.addr][8*b +: 8] <= bus.wdat[8*b +: 8];
                    end
                end
            end
            // Returns the word as it was before this access
            rdat_q <= mem[bus.addr];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign bus.rdat = rdat_q;
    assign bus.ack  = ack_q;

endmodule

// ==== source/wb_shared_bus.sv ====
// ==============================
// Wishbone shared bus
// ==============================

`include "wb_load_params.svh"

module wb_shared_bus
    import wb_load_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    wb_if.slave         m0,
    wb_if.slave         m1,
    wb_if.slave         m2,
    wb_if.master        s,
    output master_idx_t owner_o,
    output logic        busy_o
);

    master_idx_t                owner;
    logic                       busy;
    logic [`WB_NUM_MASTERS-1:0] own_v;
    logic                       cyc_mux;
    logic                       stb_mux;

    wb_bus_arbiter wb_bus_arbiter_inst (
        .clk     (clk),
        .reset   (reset),
        .req_i   ({m2.cyc, m1.cyc, m0.cyc}),
        .grant_o (owner),
        .busy_o  (busy)
    );

    // Forward path from the granted master
    always_comb begin
        cyc_mux = m0.cyc;
        stb_mux = m0.stb;
        s.we    = m0.we;
        s.addr  = m0.addr;
        s.sel   = m0.sel;
        s.cti   = m0.cti;
        s.wdat  = m0.wdat;
        case (owner)
            2'd1: begin
                cyc_mux = m1.cyc;
                stb_mux = m1.stb;
                s.we    = m1.we;
                s.addr  = m1.addr;
                s.sel   = m1.sel;
                s.cti   = m1.cti;
                s.wdat  = m1.wdat;
            end
            2'd2: begin
                cyc_mux = m2.cyc;
                stb_mux = m2.stb;
                s.we    = m2.we;
                s.addr  = m2.addr;
                s.sel   = m2.sel;
                s.cti   = m2.cti;
                s.wdat  = m2.wdat;
            end
            default: ;
        endcase
    end

    // No grant means no cycle reaches the slave
    assign s.cyc = busy && cyc_mux;
    assign s.stb = busy && cyc_mux && stb_mux;

    // Return path, only the owner sees ack and data
    assign own_v[0] = busy && (owner == master_idx_t'(0));
    assign own_v[1] = busy && (owner == master_idx_t'(1));
    assign own_v[2] = busy && (owner == master_idx_t'(2));

    assign m0.ack  = own_v[0] && s.ack;
    assign m1.ack  = own_v[1] && s.ack;
    assign m2.ack  = own_v[2] && s.ack;
    assign m0.rdat = own_v[0] ? s.rdat : '0;
    assign m1.rdat = own_v[1] ? s.rdat : '0;
    assign m2.rdat = own_v[2] ? s.rdat : '0;

    assign owner_o = owner;
    assign busy_o  = busy;

endmodule

// ==== source/wb_bus_arbiter.sv ====
// ==============================
// Round-robin bus arbiter
// ==============================

`include "wb_load_params.svh"

module wb_bus_arbiter
    import wb_load_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`WB_NUM_MASTERS-1:0] req_i,
    output master_idx_t                grant_o,
    output logic                       busy_o
);

    // owner_q is the current owner while busy and the last owner otherwise
    master_idx_t owner_q;
    logic        busy_q;
    master_idx_t pick;
    logic        pick_valid;

    // Search starts at the index after the last owner
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick       = '0;
        for (int off = 1; off <= `WB_NUM_MASTERS; off++) begin
            idx = (int'(owner_q) + off) % `WB_NUM_MASTERS;
            if (!pick_valid && req_i[idx]) begin
                pick_valid = 1'b1;
                pick       = master_idx_t'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // First search after reset begins at master 0
            owner_q <= master_idx_t'(`WB_NUM_MASTERS - 1);
            busy_q  <= 1'b0;
        end else if (busy_q) begin
            // Owner dropped cyc, bus goes idle for one cycle
            if (!req_i[owner_q]) begin
                busy_q <= 1'b0;
            end
        end else if (pick_valid) begin
            owner_q <= pick;
            busy_q  <= 1'b1;
        end
    end

    assign grant_o = owner_q;
    assign busy_o  = busy_q;

endmodule

// ==== source/wb_dummy_requester.sv ====
// ==============================
// Wishbone dummy requester
// ==============================

`include "wb_load_params.svh"

module wb_dummy_requester
    import wb_load_pkg::*;
#(
    parameter int                REQ_LEN_CLK_NUM  = `REQ_LEN_CLK_NUM_DEF,
    parameter int                REQ_WAIT_CLK_NUM = `REQ_WAIT_CLK_NUM_DEF,
    parameter logic [`WB_AW-1:0] BASE_ADDR        = '0
) (
    input  logic clk,
    input  logic reset,
    wb_if.master bus
);

    // One counter serves both the idle gap and the hold phase
    localparam int CNT_MAX = (REQ_LEN_CLK_NUM > REQ_WAIT_CLK_NUM) ?
                             REQ_LEN_CLK_NUM : REQ_WAIT_CLK_NUM;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(REQ_WAIT_CLK_NUM - 1);
    localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(REQ_LEN_CLK_NUM - 1);

    req_state_e       state_q;
    req_state_e       state_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic             active;

    // Fixed read of one word, all bytes
    assign bus.we   = 1'b0;
    assign bus.addr = BASE_ADDR;
    assign bus.sel  = '1;
    assign bus.cti  = CTI_CLASSIC;
    assign bus.wdat = '0;

    // cyc and stb follow the registered state directly
    assign active  = (state_q != ST_DELAY);
    assign bus.cyc = active;
    assign bus.stb = active;

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            ST_DELAY: begin
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == WAIT_LAST) begin
                    cnt_d   = '0;
                    state_d = ST_WAIT_ACK;
                end
            end
            ST_WAIT_ACK: begin
                // Stays here until the arbiter lets the request through
                cnt_d = '0;
                if (bus.ack) begin
                    state_d = ST_HOLD;
                end
            end
            ST_HOLD: begin
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == HOLD_LAST) begin
                    cnt_d   = '0;
                    state_d = ST_DELAY;
                end
            end
            default: begin
                cnt_d   = '0;
                state_d = ST_DELAY;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ST_DELAY;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule

// ==== source/wb_if.sv ====
// ==============================
// Wishbone bus interface
// ==============================

`include "wb_load_params.svh"

interface wb_if
    import wb_load_pkg::*;
();

    // Master to slave
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_AW-1:0]     addr;
    logic [`WB_SELW-1:0]   sel;
    wb_cti_e               cti;
    logic [`WB_DW-1:0]     wdat;

    // Slave to master
    logic [`WB_DW-1:0]     rdat;
    logic                  ack;

    modport master (
        output cyc,
        output stb,
        output we,
        output addr,
        output sel,
        output cti,
        output wdat,
        input  rdat,
        input  ack
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  addr,
        input  sel,
        input  cti,
        input  wdat,
        output rdat,
        output ack
    );

endinterface

// ==== source/wb_load_pkg.sv ====
// ==============================
// Wishbone load types
// ==============================

package wb_load_pkg;

    // Wishbone cycle type tag
    // Only classic cycles are generated in this design
    typedef enum logic [2:0] {
        CTI_CLASSIC = 3'b000,
        CTI_CONST   = 3'b001,
        CTI_INCR    = 3'b010,
        CTI_END     = 3'b111
    } wb_cti_e;

    // Index of the master that owns the shared bus
    typedef logic [1:0] master_idx_t;

    // Dummy requester phases
    typedef enum logic [1:0] {
        ST_DELAY    = 2'd0,
        ST_WAIT_ACK = 2'd1,
        ST_HOLD     = 2'd2
    } req_state_e;

endpackage

// ==== source/wb_load_params.svh ====
// ==============================
// Wishbone load parameters
// ==============================

`ifndef WB_LOAD_PARAMS_SVH
`define WB_LOAD_PARAMS_SVH

// Data width in bits, one word per access
`define WB_DW 32

// Word address width, 256 words of RAM
`define WB_AW 8

// One select bit per data byte
`define WB_SELW 4

// Master 0 is the external port, 1 and 2 are the dummy requesters
`define WB_NUM_MASTERS 3

// Cycles the requester keeps the bus after its first ack
`define REQ_LEN_CLK_NUM_DEF 10

// Idle cycles between two requests of one requester
`define REQ_WAIT_CLK_NUM_DEF 20

`endif
